//--- rtl/rp_macros.svh
// system bus and dac path constants
`ifndef RP_MACROS_SVH
`define RP_MACROS_SVH

// ------------------------------
// system bus
// ------------------------------
`define RP_REGIONS        8              // regions served by the bus
`define RP_FIRST_FREE     6              // first region with no block behind it
`define RP_DAT_W          32             // bus data width
`define RP_SEL_W          4              // byte selects
`define RP_ADR_W          32             // bus address width

// address split
`define RP_REG_HI         29             // region field msb
`define RP_REG_LO         20             // region field lsb
`define RP_OFS_W          20             // offset inside a region

// ------------------------------
// configuration window
// ------------------------------
`define RP_SYSCONF_REGION 10'h3ff        // region field of the window
`define RP_SYSCONF_ID     32'hfff00002   // class fff, version 00002

// ------------------------------
// converter and interrupts
// ------------------------------
`define RP_DAC_W          14             // converter sample width
`define RP_IRQ_W          16             // interrupt vector lines
`define RP_IRQ_GPIO       10             // housekeeping gpio change line
`define RP_IRQ_DDRD       4              // ddr dump line

`endif

//--- rtl/rp_pkg.sv
// shared bus and sample types
`default_nettype none

`include "rp_macros.svh"

package rp_pkg;

  // ------------------------------
  // system bus
  // ------------------------------

  // one request from the bus master, 70 bits
  typedef struct packed {
    logic [`RP_ADR_W-1:0] addr;   // region field plus offset
    logic [`RP_DAT_W-1:0] wdata;  // write data
    logic [`RP_SEL_W-1:0] sel;    // byte select
    logic                 wen;    // write strobe
    logic                 ren;    // read strobe
  } sys_req_t;

  // one region answer, 34 bits
  typedef struct packed {
    logic [`RP_DAT_W-1:0] rdata;  // read data
    logic                 err;    // error flag
    logic                 ack;    // level ack, same cycle
  } sys_rsp_t;

  // ------------------------------
  // converter samples
  // ------------------------------

  // two's complement pair, 28 bits
  typedef struct packed {
    logic signed [`RP_DAC_W-1:0] ch_a;  // channel a
    logic signed [`RP_DAC_W-1:0] ch_b;  // channel b
  } dac_pair_t;

endpackage

`default_nettype wire

//--- rtl/sys_region_decode.sv
// bus region decoder
`default_nettype none

`include "rp_macros.svh"

module sys_region_decode (
  input  wire rp_pkg::sys_req_t  req_i,         // request from bus master
  output logic [`RP_REGIONS-1:0] region_cs_o,   // one-hot or zero
  output logic                   conf_cs_o,     // config window hit
  output logic [`RP_REGIONS-1:0] region_wen_o,  // gated write strobes
  output logic [`RP_REGIONS-1:0] region_ren_o   // gated read strobes
);

  localparam int REG_W = `RP_REG_HI - `RP_REG_LO + 1;  // region field width
  localparam int IDX_W = $clog2(`RP_REGIONS);          // select index width

  logic [REG_W-1:0] region;  // raw region field
  logic [IDX_W-1:0] idx;     // low bits used as select index
  logic             in_map;  // field below region count

  // ------------------------------
  // region field
  // ------------------------------
  assign region = req_i.addr[`RP_REG_HI:`RP_REG_LO];  // bits 29:20
  assign idx    = region[IDX_W-1:0];
  assign in_map = (region < REG_W'(`RP_REGIONS));  // 8 and above select nothing

  // one-hot select, zero outside the map
  always_comb begin
    region_cs_o = '0;
    if (in_map) begin
      region_cs_o[idx] = 1'b1;  // single region
    end
  end

  // config window sits far above the mapped regions
  assign conf_cs_o = (region == `RP_SYSCONF_REGION);

  // ------------------------------
  // strobes
  // ------------------------------
  // zero whenever the master strobe is low
  assign region_wen_o = region_cs_o & {`RP_REGIONS{req_i.wen}};  // write per region
  assign region_ren_o = region_cs_o & {`RP_REGIONS{req_i.ren}};  // read per region

endmodule

`default_nettype wire

//--- rtl/sys_read_mux.sv
// bus response multiplexer
//   and-or merge of region and config answers
`default_nettype none

`include "rp_macros.svh"

module sys_read_mux (
  input  wire  [`RP_REGIONS-1:0]                  region_cs_i,   // one-hot select
  input  wire                                     conf_cs_i,     // config window
  input  wire  rp_pkg::sys_rsp_t [`RP_FIRST_FREE-1:0] region_rsp_i,  // mapped blocks
  input  wire  [`RP_DAT_W-1:0]                    conf_rdata_i,  // config table data
  output rp_pkg::sys_rsp_t                        rsp_o          // back to master
);

  localparam int RSP_W = $bits(rp_pkg::sys_rsp_t);  // 34 bits

  rp_pkg::sys_rsp_t [`RP_REGIONS-1:0] all_rsp;   // full region table
  rp_pkg::sys_rsp_t                   conf_rsp;  // config answer
  logic [RSP_W-1:0]                   merged;    // or of gated answers

  // ------------------------------
  // region table
  // ------------------------------
  always_comb begin
    for (int i = 0; i < `RP_REGIONS; i++) begin
      if (i < `RP_FIRST_FREE) begin
        all_rsp[i] = region_rsp_i[i];  // external block answer
      end else begin
        all_rsp[i].rdata = '0;    // free region reads zero
        all_rsp[i].err   = 1'b0;  // never errors
        all_rsp[i].ack   = 1'b1;  // so the master never stalls
      end
    end
  end

  // config window always acks, never errors
  always_comb begin
    conf_rsp.rdata = conf_rdata_i;
    conf_rsp.err   = 1'b0;
    conf_rsp.ack   = 1'b1;
  end

  // ------------------------------
  // and-or merge
  // ------------------------------
  // unselected answers are masked to zero, nothing selected gives all zero
  always_comb begin
    merged = '0;
    for (int i = 0; i < `RP_REGIONS; i++) begin
      merged = merged | (all_rsp[i] & {RSP_W{region_cs_i[i]}});  // gate by select
    end
    merged = merged | (conf_rsp & {RSP_W{conf_cs_i}});  // config window on top
  end

  assign rsp_o = merged;  // rdata, err, ack

endmodule

`default_nettype wire

//--- rtl/sysconf_regs.sv
// configuration window table
`default_nettype none

`include "rp_macros.svh"

module sysconf_regs (
  input  wire  [`RP_OFS_W-1:0] offset_i,  // offset inside the window
  output logic [`RP_DAT_W-1:0] rdata_o    // constant read data
);

  // ------------------------------
  // window offsets
  // ------------------------------
  localparam logic [`RP_OFS_W-1:0] OFS_ID      = 20'hf0000;  // id word
  localparam logic [`RP_OFS_W-1:0] OFS_REGIONS = 20'hf0004;  // region count
  localparam logic [`RP_OFS_W-1:0] OFS_ROUTE0  = 20'hf0100;  // region 0 irq routing
  localparam logic [`RP_OFS_W-1:0] OFS_ROUTE1  = 20'hf0104;  // region 1 irq routing

  // routing word, up to four lines per region
  //   bits 19:16 enable lines 0..3, bits 15:0 hold four irq numbers
  // only line 0 is used here
  function automatic logic [`RP_DAT_W-1:0] route_word(input logic [3:0] irq_num);
    logic [`RP_DAT_W-1:0] w;  // assembled word
    w        = '0;
    w[19]    = 1'b1;     // enable line 0
    w[15:12] = irq_num;  // irq number of line 0
    return w;
  endfunction

  // ------------------------------
  // lookup
  // ------------------------------
  always_comb begin
    case (offset_i)
      OFS_ID:      rdata_o = `RP_SYSCONF_ID;
      OFS_REGIONS: rdata_o = `RP_DAT_W'(`RP_REGIONS);  // 8
      OFS_ROUTE0:  rdata_o = route_word(4'(`RP_IRQ_GPIO));  // hk, 0x0008a000
      OFS_ROUTE1:  rdata_o = route_word(4'(`RP_IRQ_DDRD));  // dump, 0x00084000
      default:     rdata_o = '0;  // unlisted offset
    endcase
  end

endmodule

`default_nettype wire

//--- rtl/dac_sum_sat.sv
// dac sum with saturation
`default_nettype none

`include "rp_macros.svh"

module dac_sum_sat (
  input  wire              adc_clk,  // sample clock
  input  wire              reset_i,  // sync, active high
  input  wire  rp_pkg::dac_pair_t gen_i,  // generator samples
  input  wire  rp_pkg::dac_pair_t ctl_i,  // controller samples
  output rp_pkg::dac_pair_t       dac_o   // registered, to converter
);

  localparam int W = `RP_DAC_W;  // 14

  logic [W:0]   sum_a;  // 15 bit sum, channel a
  logic [W:0]   sum_b;  // 15 bit sum, channel b
  logic [W-1:0] sat_a;  // clipped channel a
  logic [W-1:0] sat_b;  // clipped channel b

  // top two bits of the wide sum disagree on overflow
  function automatic logic [W-1:0] saturate(input logic [W:0] sum);
    logic [1:0] top;  // sign and carry
    top = sum[W -: 2];
    case (top)
      2'b01:   saturate = {1'b0, {(W-1){1'b1}}};  // pos. overflow, 0x1fff
      2'b10:   saturate = {1'b1, {(W-1){1'b0}}};  // neg. overflow, 0x2000
      default: saturate = sum[W-1:0];             // in range
    endcase
  endfunction

  // ------------------------------
  // sum, sign extended
  // ------------------------------
  assign sum_a = {gen_i.ch_a[W-1], gen_i.ch_a} + {ctl_i.ch_a[W-1], ctl_i.ch_a};
  assign sum_b = {gen_i.ch_b[W-1], gen_i.ch_b} + {ctl_i.ch_b[W-1], ctl_i.ch_b};

  assign sat_a = saturate(sum_a);
  assign sat_b = saturate(sum_b);

  // ------------------------------
  // output register
  // ------------------------------
  // one cycle latency, new pair every clock
  always_ff @(posedge adc_clk) begin
    if (reset_i) begin
      dac_o <= '0;  // mid scale after reset
    end else begin
      dac_o.ch_a <= sat_a;
      dac_o.ch_b <= sat_b;
    end
  end

endmodule

`default_nettype wire

//--- rtl/rp_top.sv
// instrument top, bus side and dac path
`default_nettype none

`include "rp_macros.svh"

module rp_top (
  input  wire                                     adc_clk,       // single clock
  input  wire                                     reset_i,       // sync, active high

  // system bus
  input  wire  rp_pkg::sys_req_t                  sys_req_i,     // master request
  input  wire  rp_pkg::sys_rsp_t [`RP_FIRST_FREE-1:0] region_rsp_i,  // external blocks
  output logic [`RP_REGIONS-1:0]                  region_wen_o,  // per region write
  output logic [`RP_REGIONS-1:0]                  region_ren_o,  // per region read
  output rp_pkg::sys_rsp_t                        sys_rsp_o,     // merged answer

  // interrupts
  input  wire                                     irq_gpio_i,    // hk gpio change
  input  wire                                     irq_ddrd_i,    // ddr dump
  output logic [`RP_IRQ_W-1:0]                    irq_o,         // to processor

  // dac samples
  input  wire  rp_pkg::dac_pair_t                 dac_gen_i,     // generator
  input  wire  rp_pkg::dac_pair_t                 dac_ctl_i,     // controller
  output rp_pkg::dac_pair_t                       dac_o          // to converter
);

  logic [`RP_REGIONS-1:0] region_cs;   // one-hot region select
  logic                   conf_cs;     // config window select
  logic [`RP_DAT_W-1:0]   conf_rdata;  // config table data

  // ------------------------------
  // bus decode
  // ------------------------------
  sys_region_decode i_decode (
    .req_i        (sys_req_i),     // whole request
    .region_cs_o  (region_cs),     // select
    .conf_cs_o    (conf_cs),       // window hit
    .region_wen_o (region_wen_o),  // straight out
    .region_ren_o (region_ren_o)   // straight out
  );

  // config table sees only the offset
  sysconf_regs i_sysconf (
    .offset_i (sys_req_i.addr[`RP_OFS_W-1:0]),  // bits 19:0
    .rdata_o  (conf_rdata)
  );

  // ------------------------------
  // bus response
  // ------------------------------
  sys_read_mux i_read_mux (
    .region_cs_i  (region_cs),
    .conf_cs_i    (conf_cs),
    .region_rsp_i (region_rsp_i),  // regions 0..5
    .conf_rdata_i (conf_rdata),
    .rsp_o        (sys_rsp_o)      // same cycle
  );

  // ------------------------------
  // interrupt vector
  // ------------------------------
  // two child lines, the rest tied low
  always_comb begin
    irq_o               = '0;
    irq_o[`RP_IRQ_GPIO] = irq_gpio_i;  // line 10, hk
    irq_o[`RP_IRQ_DDRD] = irq_ddrd_i;  // line 4, dump
  end

  // ------------------------------
  // dac path
  // ------------------------------
  dac_sum_sat i_dac_sum (
    .adc_clk (adc_clk),
    .reset_i (reset_i),
    .gen_i   (dac_gen_i),  // generator pair
    .ctl_i   (dac_ctl_i),  // controller pair
    .dac_o   (dac_o)       // clipped, registered
  );

endmodule

`default_nettype wire

//--- bench/rp_checker.sv
// response checker for rp_top
`default_nettype none

`include "rp_macros.svh"

module rp_checker (
  input  wire                          adc_clk,
  input  wire                          reset_i,
  input  wire  [2:0]                   kind_i,        // test kind driven with the stimulus
  input  int                           test_id_i,     // record number
  input  wire  [31:0]                  exp_data_i,    // rdata, irq or dac pair
  input  wire  [31:0]                  exp_aux_i,     // strobe masks, err, ack
  input  wire  [`RP_REGIONS-1:0]       region_wen_i,  // dut outputs from here on
  input  wire  [`RP_REGIONS-1:0]       region_ren_i,
  input  wire  rp_pkg::sys_rsp_t       rsp_i,
  input  wire  [`RP_IRQ_W-1:0]         irq_i,
  input  wire  rp_pkg::dac_pair_t      dac_i,
  output int                           tests_o,       // tests closed so far
  output int                           failures_o     // tests with a mismatch
);

  localparam logic [2:0] K_BUS  = 3'd1;
  localparam logic [2:0] K_IRQ  = 3'd2;
  localparam logic [2:0] K_DAC  = 3'd3;
  localparam logic [2:0] K_LFSR = 3'd4;

  logic        rst_q    = 1'b0;  // reset seen at last edge
  logic        dac_pend = 1'b0;  // dac result due at this edge
  logic [27:0] dac_exp  = '0;
  int          dac_id   = 0;
  bit          bad      = 1'b0;  // current test has a mismatch
  int          n_run    = 0;
  int          n_bad    = 0;

  assign tests_o    = n_run;
  assign failures_o = n_bad;

  task automatic compare_word(input string sig, input logic [31:0] got,
                              input logic [31:0] exp);
    if (got !== exp) begin
      $display("mismatch %s got %h expected %h", sig, got, exp);
      bad = 1'b1;
    end
  endtask

  // one line per finished test
  task automatic close_test(input string what);
    n_run = n_run + 1;
    if (bad) begin
      n_bad = n_bad + 1;
      $display("%s failed", what);
    end else begin
      $display("%s ok", what);
    end
    bad = 1'b0;
  endtask

  // ------------------------------
  // sampling at the rising edge
  // ------------------------------
  always @(posedge adc_clk) begin
    rst_q    <= reset_i;
    dac_pend <= 1'b0;
    if (rst_q && !reset_i) begin  // first edge after release
      compare_word("dac_o", {4'h0, dac_i}, 32'h0);
      close_test("reset dac");
    end
    case (kind_i)
      K_BUS: begin  // combinational, answer of last edge's request
        compare_word("sys_rsp_o.rdata", rsp_i.rdata, exp_data_i);
        compare_word("sys_rsp_o.err", 32'(rsp_i.err), 32'(exp_aux_i[7:4]));
        compare_word("sys_rsp_o.ack", 32'(rsp_i.ack), 32'(exp_aux_i[3:0]));
        compare_word("region_wen_o", 32'(region_wen_i), 32'(exp_aux_i[23:16]));
        compare_word("region_ren_o", 32'(region_ren_i), 32'(exp_aux_i[15:8]));
        close_test($sformatf("test %0d bus", test_id_i));
      end
      K_IRQ: begin
        compare_word("irq_o", 32'(irq_i), exp_data_i);
        close_test($sformatf("test %0d irq", test_id_i));
      end
      K_DAC, K_LFSR: begin  // registered, look one edge later
        dac_pend <= 1'b1;
        dac_exp  <= exp_data_i[27:0];
        dac_id   <= test_id_i;
      end
      default: ;
    endcase
    if (dac_pend) begin
      compare_word("dac_o", {4'h0, dac_i}, {4'h0, dac_exp});
      close_test($sformatf("test %0d dac", dac_id));
    end
  end

endmodule

`default_nettype wire

//--- bench/tb_rp_top.sv
// rp_top testbench
`default_nettype none

`include "rp_macros.svh"

module tb_rp_top;

  localparam int         MAX_TESTS = 64;  // room in pattern memory
  localparam int         REC_W     = 15;  // words per record
  localparam int         RST_CYC   = 3;   // reset length
  localparam logic [2:0] K_LFSR    = 3'd4;
  localparam int         DAC_MAX   = 2**(`RP_DAC_W-1) - 1;  // 8191
  localparam int         DAC_MIN   = -(2**(`RP_DAC_W-1));   // -8192

  logic                                  adc_clk = 1'b0;
  logic                                  reset_i;
  rp_pkg::sys_req_t                      sys_req;
  rp_pkg::sys_rsp_t [`RP_FIRST_FREE-1:0] region_rsp;  // external block answers
  logic [`RP_REGIONS-1:0]                region_wen;
  logic [`RP_REGIONS-1:0]                region_ren;
  rp_pkg::sys_rsp_t                      sys_rsp;
  logic                                  irq_gpio;
  logic                                  irq_ddrd;
  logic [`RP_IRQ_W-1:0]                  irq;
  rp_pkg::dac_pair_t                     dac_gen;
  rp_pkg::dac_pair_t                     dac_ctl;
  rp_pkg::dac_pair_t                     dac;

  logic [2:0]  kind;      // to checker
  int          test_id;
  logic [31:0] exp_data;
  logic [31:0] exp_aux;
  int          tests_run;
  int          failures;

  logic [31:0] pat_mem [0:MAX_TESTS*REC_W-1];
  logic [15:0] lfsr_q;
  int          n_tests;
  int          cycles = 0;
  int          limit  = 1000000;  // replaced once the file is read

  always #5 adc_clk = ~adc_clk;  // period 10

  // ------------------------------
  // run limit
  // ------------------------------
  always @(posedge adc_clk) begin
    cycles <= cycles + 1;
    if (cycles >= limit) begin
      $display("timeout after %0d cycles, the run did not reach its end", cycles);
      $display("*** FAILED ***");
      $finish;
    end
  end

  // fibonacci lfsr, x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    logic fb;
    fb = s[15] ^ s[13] ^ s[12] ^ s[10];
    return {s[14:0], fb};
  endfunction

  task automatic take_sample(output logic [`RP_DAC_W-1:0] v);
    v = '0;
    for (int i = 0; i < `RP_DAC_W; i++) begin
      lfsr_q = lfsr_next(lfsr_q);             // one step per bit
      v      = {v[`RP_DAC_W-2:0], lfsr_q[0]};
    end
  endtask

  // signed sum clamped to the converter range
  function automatic logic [`RP_DAC_W-1:0] sat_sum(input logic [`RP_DAC_W-1:0] a,
                                                   input logic [`RP_DAC_W-1:0] b);
    int s;
    s = int'($signed(a)) + int'($signed(b));
    if (s > DAC_MAX) begin
      s = DAC_MAX;
    end else if (s < DAC_MIN) begin
      s = DAC_MIN;
    end
    return s[`RP_DAC_W-1:0];
  endfunction

  // ------------------------------
  // one record onto the ports
  // ------------------------------
  task automatic apply_test(input int t);
    int                                    b;
    rp_pkg::sys_req_t                      req;
    rp_pkg::sys_rsp_t [`RP_FIRST_FREE-1:0] rsp;
    rp_pkg::dac_pair_t                     g;
    rp_pkg::dac_pair_t                     c;
    logic [31:0]                           ea;
    logic [31:0]                           ex;
    logic [`RP_DAC_W-1:0]                  ga, gb, ca, cb;
    b         = t * REC_W;
    ea        = pat_mem[b+12];  // err and ack pairs per region
    req       = '0;
    req.addr  = pat_mem[b+1];
    req.wdata = ~pat_mem[b+1];  // not read back
    req.sel   = '1;
    req.wen   = pat_mem[b+2][1];
    req.ren   = pat_mem[b+2][0];
    for (int i = 0; i < `RP_FIRST_FREE; i++) begin
      rsp[i].rdata = pat_mem[b+6+i];  // region tag
      rsp[i].err   = ea[2*i+1];
      rsp[i].ack   = ea[2*i];
    end
    if (pat_mem[b][2:0] == K_LFSR) begin
      take_sample(ga);
      take_sample(gb);
      take_sample(ca);
      take_sample(cb);
      g  = {ga, gb};
      c  = {ca, cb};
      ex = {4'h0, sat_sum(ga, ca), sat_sum(gb, cb)};
    end else begin
      g  = pat_mem[b+4][27:0];
      c  = pat_mem[b+5][27:0];
      ex = pat_mem[b+13];
    end
    sys_req    <= req;
    region_rsp <= rsp;
    irq_gpio   <= pat_mem[b+3][1];
    irq_ddrd   <= pat_mem[b+3][0];
    dac_gen    <= g;
    dac_ctl    <= c;
    kind       <= pat_mem[b][2:0];
    test_id    <= t;
    exp_data   <= ex;
    exp_aux    <= pat_mem[b+14];
  endtask

  rp_top i_rp_top (
    .adc_clk      (adc_clk),
    .reset_i      (reset_i),
    .sys_req_i    (sys_req),
    .region_rsp_i (region_rsp),
    .region_wen_o (region_wen),
    .region_ren_o (region_ren),
    .sys_rsp_o    (sys_rsp),
    .irq_gpio_i   (irq_gpio),
    .irq_ddrd_i   (irq_ddrd),
    .irq_o        (irq),
    .dac_gen_i    (dac_gen),
    .dac_ctl_i    (dac_ctl),
    .dac_o        (dac)
  );

  rp_checker i_checker (
    .adc_clk      (adc_clk),
    .reset_i      (reset_i),
    .kind_i       (kind),
    .test_id_i    (test_id),
    .exp_data_i   (exp_data),
    .exp_aux_i    (exp_aux),
    .region_wen_i (region_wen),
    .region_ren_i (region_ren),
    .rsp_i        (sys_rsp),
    .irq_i        (irq),
    .dac_i        (dac),
    .tests_o      (tests_run),
    .failures_o   (failures)
  );

  // ------------------------------
  // main sequence
  // ------------------------------
  initial begin
    reset_i    <= 1'b1;
    sys_req    <= '0;
    region_rsp <= '0;
    irq_gpio   <= 1'b0;
    irq_ddrd   <= 1'b0;
    dac_gen    <= 28'h0123456;  // nonzero, zero dac_o then comes from reset
    dac_ctl    <= '0;
    kind       <= '0;
    test_id    <= 0;
    exp_data   <= '0;
    exp_aux    <= '0;
    lfsr_q      = 16'd98;       // seed
    for (int i = 0; i < MAX_TESTS*REC_W; i++) begin
      pat_mem[i] = '0;
    end
    $readmemh("bench/rp_patterns.txt", pat_mem);
    n_tests = 0;
    while (n_tests < MAX_TESTS && pat_mem[n_tests*REC_W] != 0) begin
      n_tests = n_tests + 1;    // kind 0 ends the list
    end
    limit = (n_tests + RST_CYC + 20) * 2;
    repeat (RST_CYC) @(posedge adc_clk);
    reset_i <= 1'b0;
    for (int t = 0; t < n_tests; t++) begin
      @(posedge adc_clk);
      apply_test(t);            // one record per cycle
    end
    @(posedge adc_clk);
    kind <= '0;                 // idle while the last dac result drains
    repeat (2) @(posedge adc_clk);
    if (n_tests == 0) begin
      $display("no test records were read from bench/rp_patterns.txt");
    end else if (tests_run != n_tests + 1) begin
      $display("only %0d of %0d tests were checked", tests_run, n_tests + 1);
    end
    $display("summary %0d tests run, %0d failed", tests_run, failures);
    if (n_tests > 0 && tests_run == n_tests + 1 && failures == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- files.f
+incdir+rtl
rtl/rp_pkg.sv
rtl/sys_region_decode.sv
rtl/sys_read_mux.sv
rtl/sysconf_regs.sv
rtl/dac_sum_sat.sv
rtl/rp_top.sv
bench/rp_checker.sv
bench/tb_rp_top.sv

//--- run.sh
#!/usr/bin/env bash
# compile and run the rp_top testbench with verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing -j 0 \
  -f files.f \
  --top-module tb_rp_top \
  -o sim_rp_top

./obj_dir/sim_rp_top | tee sim.log

if grep -q '\*\*\* FAILED \*\*\*' sim.log; then
  echo "simulation reported a failure"
  exit 1
fi
echo "simulation finished without failures"

//--- bench/rp_patterns.txt
// kind addr strobes irq gen ctl tag0 tag1 tag2 tag3 tag4 tag5 err_ack exp_data exp_aux
// kind 1 bus 2 irq 3 dac 4 lfsr dac   exp_aux is wen[23:16] ren[15:8] err[7:4] ack[3:0]
1 00000000 1 0 0000000 0000000 a0a0 b1b1 c2c2 d3d3 e4e4 f5f5 475 0000a0a0 000101
1 00100000 1 0 0000000 0000000 a0a0 b1b1 c2c2 d3d3 e4e4 f5f5 475 0000b1b1 000201
1 00200000 1 0 0000000 0000000 a0a0 b1b1 c2c2 d3d3 e4e4 f5f5 475 0000c2c2 000411
1 00300000 1 0 0000000 0000000 a0a0 b1b1 c2c2 d3d3 e4e4 f5f5 475 0000d3d3 000801
1 00400000 1 0 0000000 0000000 a0a0 b1b1 c2c2 d3d3 e4e4 f5f5 475 0000e4e4 001000
1 00500000 1 0 0000000 0000000 a0a0 b1b1 c2c2 d3d3 e4e4 f5f5 475 0000f5f5 002001
1 00100000 2 0 0000000 0000000 a0a0 b1b1 c2c2 d3d3 e4e4 f5f5 475 0000b1b1 020001
1 00500010 2 0 0000000 0000000 a0a0 b1b1 c2c2 d3d3 e4e4 f5f5 475 0000f5f5 200001
1 00600000 1 0 0000000 0000000 a0a0 b1b1 c2c2 d3d3 e4e4 f5f5 475 00000000 004001
1 00700000 1 0 0000000 0000000 a0a0 b1b1 c2c2 d3d3 e4e4 f5f5 475 00000000 008001
1 00800000 1 0 0000000 0000000 a0a0 b1b1 c2c2 d3d3 e4e4 f5f5 475 00000000 000000
1 3fe00000 1 0 0000000 0000000 a0a0 b1b1 c2c2 d3d3 e4e4 f5f5 475 00000000 000000
1 3fff0000 1 0 0000000 0000000 a0a0 b1b1 c2c2 d3d3 e4e4 f5f5 475 fff00002 000001
1 3fff0004 1 0 0000000 0000000 a0a0 b1b1 c2c2 d3d3 e4e4 f5f5 475 00000008 000001
1 3fff0100 1 0 0000000 0000000 a0a0 b1b1 c2c2 d3d3 e4e4 f5f5 475 0008a000 000001
1 3fff0104 1 0 0000000 0000000 a0a0 b1b1 c2c2 d3d3 e4e4 f5f5 475 00084000 000001
1 3fff0008 1 0 0000000 0000000 a0a0 b1b1 c2c2 d3d3 e4e4 f5f5 475 00000000 000001
2 00000000 0 2 0000000 0000000 0 0 0 0 0 0 000 00000400 000000
2 00000000 0 1 0000000 0000000 0 0 0 0 0 0 000 00000010 000000
2 00000000 0 3 0000000 0000000 0 0 0 0 0 0 000 00000410 000000
3 00000000 0 0 4000fff 4000001 0 0 0 0 0 0 000 07ffd000 000000
3 00000000 0 0 8003800 fffc100 0 0 0 0 0 0 000 08003900 000000
3 00000000 0 0 048fff0 1158005 0 0 0 0 0 0 000 015e7ff5 000000
4 00000000 0 0 0000000 0000000 0 0 0 0 0 0 000 00000000 000000
4 00000000 0 0 0000000 0000000 0 0 0 0 0 0 000 00000000 000000
4 00000000 0 0 0000000 0000000 0 0 0 0 0 0 000 00000000 000000
